/* hdl/bridge_settings.svh */
// ------------------------------------------------
// Build-time sizes of the AXI to APB bridge
// Included by the package and by the bridge top level
// ------------------------------------------------

`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// AXI side
`define BRIDGE_AXI_ADDR_W 32   // Full AXI address
`define BRIDGE_ID_W       4    // Transaction ID

// APB side
`define BRIDGE_APB_ADDR_W 12   // 4 KB window per slave
`define BRIDGE_NUM_SLAVES 8    // Selected by address bits 14:12

// Request queues
`define BRIDGE_FIFO_DEPTH 2    // Entries per AXI channel

`endif

/* hdl/bridge_pkg.sv */
// ------------------------------------------------
// Types shared by the bridge RTL and its testbench
// ------------------------------------------------
`default_nettype none

`include "bridge_settings.svh"

package bridge_pkg;

  typedef logic [`BRIDGE_AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`BRIDGE_ID_W-1:0] axi_id_t;
  typedef logic [`BRIDGE_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [$clog2(`BRIDGE_NUM_SLAVES)-1:0] slave_sel_t;
  typedef logic [31:0] word_t;
  typedef logic [1:0][31:0] dword_t;         // Index 1 is the upper lane

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Queued AW or AR request
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    logic      is_64;                        // Size 3 access in two APB words
  } addr_req_t;

  typedef dword_t wbeat_t;                   // Queued W beat

  typedef logic [`BRIDGE_NUM_SLAVES-1:0][31:0] slave_words_t;
  typedef logic [`BRIDGE_NUM_SLAVES-1:0] slave_bits_t;

endpackage

`default_nettype wire

/* hdl/chan_fifo.sv */
// ------------------------------------------------
// Small circular queue for one AXI request channel
// The payload type is set per instance
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module chan_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     ACLK,
  input  logic     ARESETn,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign push_ready_o = (count != CNT_W'(DEPTH));   // Not full
  assign pop_valid_o  = (count != '0);               // Not empty
  assign pop_data_o   = mem[rd_ptr];
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (push)
      mem[wr_ptr] <= push_data_i;
  end

endmodule

`default_nettype wire

/* hdl/apb_req_if.sv */
// ------------------------------------------------
// Word request path from the beat sequencer to the APB master
// Fields hold steady from req until done
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface apb_req_if;
  import bridge_pkg::*;

  logic  req_o;                                          // Held until done
  logic  write_o;
  logic  [$bits(slave_sel_t)+$bits(apb_addr_t)-1:0] addr_o;  // Slave index and offset
  word_t wdata_o;

  logic  done_o;                                         // One cycle as the access ends
  word_t rdata_o;
  logic  err_o;

  modport seq (
    output req_o, write_o, addr_o, wdata_o,
    input  done_o, rdata_o, err_o
  );

  modport mst (
    input  req_o, write_o, addr_o, wdata_o,
    output done_o, rdata_o, err_o
  );

endinterface

`default_nettype wire

/* hdl/apb_master.sv */
// ------------------------------------------------
// APB3 master with separate setup and access phases
// Decodes PSEL and returns the addressed slave's response
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apb_master (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  apb_req_if.mst                   req,
  output bridge_pkg::apb_addr_t    paddr_o,
  output bridge_pkg::slave_bits_t  psel_o,
  output logic                     penable_o,
  output logic                     pwrite_o,
  output bridge_pkg::word_t        pwdata_o,
  input  bridge_pkg::slave_words_t prdata_i,
  input  bridge_pkg::slave_bits_t  pready_i,
  input  bridge_pkg::slave_bits_t  pslverr_i
);
  import bridge_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_SETUP,
    M_ACCESS
  } mst_state_t;

  mst_state_t state_q;
  mst_state_t state_d;
  slave_sel_t sel;
  apb_addr_t  offset;
  logic       pready_sel;

  assign {sel, offset} = req.addr_o;

  // ------------------------------------------------
  // Bus outputs
  // ------------------------------------------------
  assign paddr_o    = offset;
  assign pwrite_o   = req.write_o;
  assign pwdata_o   = req.wdata_o;
  assign penable_o  = (state_q == M_ACCESS);
  assign pready_sel = pready_i[sel];

  always_comb
  begin
    psel_o = '0;
    if (state_q != M_IDLE)
      psel_o[sel] = 1'b1;                   // One-hot during setup and access
  end

  assign req.done_o  = (state_q == M_ACCESS) && pready_sel;
  assign req.rdata_o = prdata_i[sel];
  assign req.err_o   = pslverr_i[sel];

  // ------------------------------------------------
  // Phase sequencing
  // ------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      M_IDLE:   if (req.req_o) state_d = M_SETUP;
      M_SETUP:  state_d = M_ACCESS;         // Setup lasts one cycle
      M_ACCESS: if (pready_sel) state_d = M_IDLE;
      default:  state_d = M_IDLE;
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      state_q <= M_IDLE;
    else
      state_q <= state_d;
  end

endmodule

`default_nettype wire

/* hdl/beat_sequencer.sv */
// ------------------------------------------------
// Picks one queued AXI request at a time, splits it into APB words
// and holds the B or R response until the master accepts it
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module beat_sequencer (
  input  logic                  ACLK,
  input  logic                  ARESETn,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  bridge_pkg::addr_req_t aw_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  bridge_pkg::wbeat_t    w_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  bridge_pkg::addr_req_t ar_i,
  apb_req_if.seq                apb,
  output bridge_pkg::axi_id_t   bid_o,
  output bridge_pkg::resp_t     bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output bridge_pkg::axi_id_t   rid_o,
  output bridge_pkg::dword_t    rdata_o,
  output bridge_pkg::resp_t     rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i
);
  import bridge_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WORD0,
    S_WORD1,
    S_BRESP,
    S_RRESP
  } seq_state_t;

  seq_state_t state_q;
  seq_state_t state_d;
  seq_state_t resp_state;
  logic       write_q;                          // Current access is a write
  logic       err_q;                            // PSLVERR seen on any word
  addr_req_t  cur_q;
  wbeat_t     wbeat_q;
  dword_t     rdata_q;
  logic       start_rd;
  logic       start_wr;
  logic       lane;
  apb_addr_t  base_off;
  slave_sel_t sel;

  // Reads win over writes at the queue heads
  assign start_rd   = (state_q == S_IDLE) && ar_valid_i;
  assign start_wr   = (state_q == S_IDLE) && !ar_valid_i && aw_valid_i && w_valid_i;
  assign ar_ready_o = start_rd;
  assign aw_ready_o = start_wr;                 // AW and W leave together
  assign w_ready_o  = start_wr;

  // ------------------------------------------------
  // Word request fields
  // ------------------------------------------------
  assign base_off = cur_q.addr[$bits(apb_addr_t)-1:0];
  assign sel      = cur_q.addr[$bits(apb_addr_t) +: $bits(slave_sel_t)];
  assign lane     = cur_q.is_64 ? (state_q == S_WORD1) : cur_q.addr[2];

  assign apb.req_o   = (state_q == S_WORD0) || (state_q == S_WORD1);
  assign apb.write_o = write_q;
  assign apb.addr_o  = {sel, (state_q == S_WORD1) ? base_off + apb_addr_t'(4) : base_off};
  assign apb.wdata_o = wbeat_q[lane];

  // ------------------------------------------------
  // AXI responses
  // ------------------------------------------------
  assign bvalid_o = (state_q == S_BRESP);
  assign bid_o    = cur_q.id;
  assign bresp_o  = err_q ? RESP_SLVERR : RESP_OKAY;
  assign rvalid_o = (state_q == S_RRESP);
  assign rid_o    = cur_q.id;
  assign rdata_o  = rdata_q;
  assign rresp_o  = err_q ? RESP_SLVERR : RESP_OKAY;

  assign resp_state = write_q ? S_BRESP : S_RRESP;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (start_rd || start_wr) state_d = S_WORD0;
      S_WORD0: if (apb.done_o) state_d = cur_q.is_64 ? S_WORD1 : resp_state;
      S_WORD1: if (apb.done_o) state_d = resp_state;
      S_BRESP: if (bready_i) state_d = S_IDLE;
      S_RRESP: if (rready_i) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q <= S_IDLE;
      write_q <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (start_rd || start_wr)
      begin
        write_q <= start_wr;
        err_q   <= 1'b0;
      end
      else if (apb.done_o)
        err_q <= err_q | apb.err_o;           // Any failing word fails the access
    end
  end

  // Request, write beat and gathered read words
  always_ff @(posedge ACLK)
  begin
    if (start_rd)
    begin
      cur_q   <= ar_i;
      rdata_q <= '0;                          // Unused lane reads as zero
    end
    else if (start_wr)
    begin
      cur_q   <= aw_i;
      wbeat_q <= w_i;
    end
    if (apb.done_o && !write_q)
      rdata_q[lane] <= apb.rdata_o;
  end

endmodule

`default_nettype wire

/* hdl/axi_apb_bridge.sv */
// ------------------------------------------------
// AXI4 single-beat slave to APB3 master bridge, top level
// Queues AW, W and AR, then serves one access at a time
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module axi_apb_bridge (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  // Write address
  input  bridge_pkg::axi_id_t      awid_i,
  input  bridge_pkg::axi_addr_t    awaddr_i,
  input  logic [2:0]               awsize_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  // Write data
  input  bridge_pkg::dword_t       wdata_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  // Write response
  output bridge_pkg::axi_id_t      bid_o,
  output bridge_pkg::resp_t        bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  // Read address
  input  bridge_pkg::axi_id_t      arid_i,
  input  bridge_pkg::axi_addr_t    araddr_i,
  input  logic [2:0]               arsize_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  // Read data
  output bridge_pkg::axi_id_t      rid_o,
  output bridge_pkg::dword_t       rdata_o,
  output bridge_pkg::resp_t        rresp_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  // APB
  output bridge_pkg::apb_addr_t    paddr_o,
  output bridge_pkg::slave_bits_t  psel_o,
  output logic                     penable_o,
  output logic                     pwrite_o,
  output bridge_pkg::word_t        pwdata_o,
  input  bridge_pkg::slave_words_t prdata_i,
  input  bridge_pkg::slave_bits_t  pready_i,
  input  bridge_pkg::slave_bits_t  pslverr_i
);
  import bridge_pkg::*;

  localparam logic [2:0] SIZE_64 = 3'd3;

  addr_req_t aw_push;
  addr_req_t ar_push;
  addr_req_t aw_head;
  addr_req_t ar_head;
  wbeat_t    w_head;
  logic      aw_head_valid, aw_pop;
  logic      w_head_valid, w_pop;
  logic      ar_head_valid, ar_pop;

  assign aw_push = '{id: awid_i, addr: awaddr_i, is_64: (awsize_i == SIZE_64)};
  assign ar_push = '{id: arid_i, addr: araddr_i, is_64: (arsize_i == SIZE_64)};

  // ------------------------------------------------
  // Request queues
  // ------------------------------------------------
  chan_fifo #(.payload_t(addr_req_t), .DEPTH(`BRIDGE_FIFO_DEPTH)) aw_q (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .push_valid_i(awvalid_i), .push_ready_o(awready_o), .push_data_i(aw_push),
    .pop_valid_o(aw_head_valid), .pop_ready_i(aw_pop), .pop_data_o(aw_head)
  );

  chan_fifo #(.payload_t(wbeat_t), .DEPTH(`BRIDGE_FIFO_DEPTH)) w_q (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .push_valid_i(wvalid_i), .push_ready_o(wready_o), .push_data_i(wdata_i),
    .pop_valid_o(w_head_valid), .pop_ready_i(w_pop), .pop_data_o(w_head)
  );

  chan_fifo #(.payload_t(addr_req_t), .DEPTH(`BRIDGE_FIFO_DEPTH)) ar_q (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .push_valid_i(arvalid_i), .push_ready_o(arready_o), .push_data_i(ar_push),
    .pop_valid_o(ar_head_valid), .pop_ready_i(ar_pop), .pop_data_o(ar_head)
  );

  // ------------------------------------------------
  // Sequencer and APB master
  // ------------------------------------------------
  apb_req_if apb_if ();

  beat_sequencer i_beat_sequencer (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .aw_valid_i(aw_head_valid), .aw_ready_o(aw_pop), .aw_i(aw_head),
    .w_valid_i(w_head_valid), .w_ready_o(w_pop), .w_i(w_head),
    .ar_valid_i(ar_head_valid), .ar_ready_o(ar_pop), .ar_i(ar_head),
    .apb(apb_if.seq),
    .bid_o(bid_o), .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
    .rid_o(rid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o),
    .rready_i(rready_i)
  );

  apb_master i_apb_master (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .req(apb_if.mst),
    .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o),
    .pwdata_o(pwdata_o), .prdata_i(prdata_i), .pready_i(pready_i),
    .pslverr_i(pslverr_i)
  );

endmodule

`default_nettype wire

/* tests/apb_slave_model.sv */
// ------------------------------------------------
// Eight behavioural APB3 slaves with word memories and random waits
// Slave 7 answers every access with PSLVERR and reads as zero
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apb_slave_model (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  bridge_pkg::apb_addr_t    paddr_i,
  input  bridge_pkg::slave_bits_t  psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  bridge_pkg::word_t        pwdata_i,
  output bridge_pkg::slave_words_t prdata_o,
  output bridge_pkg::slave_bits_t  pready_o,
  output bridge_pkg::slave_bits_t  pslverr_o
);
  import bridge_pkg::*;

  localparam int NUM_SLAVES = $bits(slave_bits_t);
  localparam int ERR_SLAVE  = 7;

  word_t       mem [NUM_SLAVES][1024];
  integer      seed;
  logic [1:0]  wait_cnt;                       // One counter serves every slave

  initial seed = 32'h730699f9;

  always @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      wait_cnt <= '0;
    else if (|psel_i && !penable_i)
      wait_cnt <= 2'($unsigned($random(seed)));  // New wait count in setup
    else if (|psel_i && penable_i && wait_cnt != 0)
      wait_cnt <= wait_cnt - 1'b1;
  end

  always @(posedge ACLK)
  begin
    for (int s = 0; s < NUM_SLAVES; s++)
      if (psel_i[s] && penable_i && pwrite_i && wait_cnt == 0 && s != ERR_SLAVE)
        mem[s][paddr_i[11:2]] <= pwdata_i;
  end

  always_comb
  begin
    for (int s = 0; s < NUM_SLAVES; s++)
    begin
      pready_o[s]  = (wait_cnt == 0);
      pslverr_o[s] = (s == ERR_SLAVE);
      prdata_o[s]  = (s == ERR_SLAVE) ? 32'h0 : mem[s][paddr_i[11:2]];
    end
  end

endmodule

`default_nettype wire

/* tests/tb_axi_apb_bridge.sv */
// ------------------------------------------------
// Table-driven testbench for the AXI to APB bridge
// Rows are applied in order against the APB slave model
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_axi_apb_bridge;
  import bridge_pkg::*;

  localparam int OP_WR      = 0;
  localparam int OP_RD      = 1;
  localparam int OP_WR_PAIR = 2;                 // Two queued writes at addr and addr+8
  localparam int TIMEOUT    = 200;

  typedef struct {
    int          op;
    logic [2:0]  size;
    axi_addr_t   addr;
    logic [63:0] wdata;
    axi_id_t     id;
    int          delay;                          // Cycles before BREADY or RREADY
    resp_t       resp;
    logic [63:0] rdata;
  } row_t;

  logic ACLK = 1'b0;
  logic ARESETn;
  axi_id_t awid_i, arid_i, bid_o, rid_o;
  axi_addr_t awaddr_i, araddr_i;
  logic [2:0] awsize_i, arsize_i;
  logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic arvalid_i, arready_o, rvalid_o, rready_i, penable_o, pwrite_o;
  dword_t wdata_i, rdata_o;
  resp_t bresp_o, rresp_o;
  apb_addr_t paddr_o;
  slave_bits_t psel_o, pready_i, pslverr_i;
  word_t pwdata_o;
  slave_words_t prdata_i;
  row_t rows [$];
  int err_count = 0;

  // APB bus state seen at the previous falling edge
  logic [52:0] apb_prev;                         // PSEL, PADDR, PWRITE, PWDATA
  logic        setup_prev;
  logic        stall_prev;                       // Access phase without PREADY

  always #5 ACLK = ~ACLK;

  axi_apb_bridge i_dut (.*);

  apb_slave_model i_slaves (
    .ACLK(ACLK), .ARESETn(ARESETn), .paddr_i(paddr_o), .psel_i(psel_o),
    .penable_i(penable_o), .pwrite_i(pwrite_o), .pwdata_i(pwdata_o),
    .prdata_o(prdata_i), .pready_o(pready_i), .pslverr_o(pslverr_i)
  );

  task automatic report_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act)
    begin
      err_count++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  // Setup then access, with the transfer fields steady across both phases
  always @(negedge ACLK)
  begin
    if (ARESETn)
    begin
      check_value("apb psel one-hot", 1, $onehot0(psel_o));
      if (setup_prev || stall_prev)
        check_value("apb access phase", 1, penable_o);
      if (penable_o)
      begin
        check_value("apb access after setup", 1, setup_prev || stall_prev);
        check_value("apb fields held", apb_prev, {psel_o, paddr_o, pwrite_o, pwdata_o});
      end
    end
    apb_prev   = {psel_o, paddr_o, pwrite_o, pwdata_o};
    setup_prev = |psel_o && !penable_o;
    stall_prev = penable_o && !(|(psel_o & pready_i));
  end

  task automatic add_row(int op, logic [2:0] size, axi_addr_t addr, logic [63:0] wdata,
                         axi_id_t id, int delay, resp_t resp, logic [63:0] rdata);
    row_t r;
    r = '{op, size, addr, wdata, id, delay, resp, rdata};
    rows.push_back(r);
  endtask

  // Drive AW and W together; each is dropped after its own handshake
  task automatic apply_write(axi_id_t id, logic [2:0] size, axi_addr_t addr, logic [63:0] d);
    bit aw_done, w_done;
    int cnt;
    aw_done = 0;
    w_done  = 0;
    cnt     = 0;
    awid_i   = id;
    awaddr_i = addr;
    awsize_i = size;
    wdata_i  = d;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    while (!(aw_done && w_done))
    begin
      if (awvalid_i && awready_o) aw_done = 1;
      if (wvalid_i && wready_o) w_done = 1;
      @(negedge ACLK);
      if (aw_done) awvalid_i = 1'b0;
      if (w_done) wvalid_i = 1'b0;
      if (++cnt > TIMEOUT)
      begin
        $display("Timeout waiting for AWREADY or WREADY");
        report_failure();
      end
    end
  endtask

  task automatic apply_read(axi_id_t id, logic [2:0] size, axi_addr_t addr);
    int cnt;
    cnt = 0;
    arid_i   = id;
    araddr_i = addr;
    arsize_i = size;
    arvalid_i = 1'b1;
    while (!arready_o)
    begin
      @(negedge ACLK);
      if (++cnt > TIMEOUT)
      begin
        $display("Timeout waiting for ARREADY");
        report_failure();
      end
    end
    @(negedge ACLK);
    arvalid_i = 1'b0;
  endtask

  // Response must stay stable while BREADY is held low
  task automatic collect_bresp(string name, axi_id_t id, int delay, resp_t resp);
    int cnt;
    cnt = 0;
    while (!bvalid_o)
    begin
      @(negedge ACLK);
      if (++cnt > TIMEOUT)
      begin
        $display("Timeout waiting for BVALID in %s", name);
        report_failure();
      end
    end
    for (int i = 0; i < delay; i++)
    begin
      check_value({name, " bvalid held"}, 1, bvalid_o);
      check_value({name, " bid held"}, id, bid_o);
      check_value({name, " bresp held"}, resp, bresp_o);
      @(negedge ACLK);
    end
    check_value({name, " bvalid"}, 1, bvalid_o);
    check_value({name, " bid"}, id, bid_o);
    check_value({name, " bresp"}, resp, bresp_o);
    bready_i = 1'b1;
    @(negedge ACLK);
    bready_i = 1'b0;
  endtask

  task automatic collect_rresp(string name, axi_id_t id, int delay, resp_t resp,
                               logic [63:0] data);
    int cnt;
    cnt = 0;
    while (!rvalid_o)
    begin
      @(negedge ACLK);
      if (++cnt > TIMEOUT)
      begin
        $display("Timeout waiting for RVALID in %s", name);
        report_failure();
      end
    end
    repeat (delay) @(negedge ACLK);
    check_value({name, " rvalid"}, 1, rvalid_o);
    check_value({name, " rid"}, id, rid_o);
    check_value({name, " rresp"}, resp, rresp_o);
    check_value({name, " rdata"}, data, rdata_o);
    rready_i = 1'b1;
    @(negedge ACLK);
    rready_i = 1'b0;
  endtask

  initial
  begin
    row_t r;
    string name;
    ARESETn = 1'b0;
    awid_i = '0;
    awaddr_i = '0;
    awsize_i = '0;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wvalid_i = 1'b0;
    bready_i = 1'b0;
    arid_i = '0;
    araddr_i = '0;
    arsize_i = '0;
    arvalid_i = 1'b0;
    rready_i = 1'b0;

    // Bit 2 picks the upper 32-bit lane
    add_row(OP_WR, 3'd2, 32'h0000_0104, 64'hAAAA_1111_BBBB_2222, 4'd1, 0, RESP_OKAY, 0);
    add_row(OP_RD, 3'd2, 32'h0000_0104, 0, 4'd2, 1, RESP_OKAY, 64'hAAAA_1111_0000_0000);
    add_row(OP_WR, 3'd2, 32'h0000_0100, 64'hDDDD_4444_CCCC_3333, 4'd3, 0, RESP_OKAY, 0);
    add_row(OP_RD, 3'd2, 32'h0000_0100, 0, 4'd4, 0, RESP_OKAY, 64'h0000_0000_CCCC_3333);
    // 64-bit split into two words
    add_row(OP_WR, 3'd3, 32'h0000_2200, 64'h1234_5678_9ABC_DEF0, 4'd5, 2, RESP_OKAY, 0);
    add_row(OP_RD, 3'd2, 32'h0000_2200, 0, 4'd6, 0, RESP_OKAY, 64'h0000_0000_9ABC_DEF0);
    add_row(OP_RD, 3'd2, 32'h0000_2204, 0, 4'd7, 0, RESP_OKAY, 64'h1234_5678_0000_0000);
    add_row(OP_RD, 3'd3, 32'h0000_2200, 0, 4'd8, 0, RESP_OKAY, 64'h1234_5678_9ABC_DEF0);
    // Slave decode with upper address bits ignored
    add_row(OP_WR, 3'd2, 32'hFFFF_8010, 64'h0000_0000_1111_1111, 4'd9, 0, RESP_OKAY, 0);
    add_row(OP_WR, 3'd2, 32'h0000_3010, 64'h0000_0000_2222_2222, 4'd10, 0, RESP_OKAY, 0);
    add_row(OP_WR, 3'd2, 32'h0000_6010, 64'h0000_0000_3333_3333, 4'd11, 0, RESP_OKAY, 0);
    add_row(OP_RD, 3'd2, 32'h0001_0010, 0, 4'd12, 0, RESP_OKAY, 64'h0000_0000_1111_1111);
    add_row(OP_RD, 3'd2, 32'h0000_3010, 0, 4'd13, 0, RESP_OKAY, 64'h0000_0000_2222_2222);
    add_row(OP_RD, 3'd2, 32'h0000_6010, 0, 4'd14, 0, RESP_OKAY, 64'h0000_0000_3333_3333);
    // Error slave
    add_row(OP_WR, 3'd2, 32'h0000_7000, 64'h5555_5555_5555_5555, 4'd15, 0, RESP_SLVERR, 0);
    add_row(OP_RD, 3'd3, 32'h0000_7000, 0, 4'd0, 0, RESP_SLVERR, 0);
    // Queued writes with BREADY held low
    add_row(OP_WR_PAIR, 3'd3, 32'h0000_1040, 64'h0F0F_1E1E_2D2D_3C3C, 4'd6, 5, RESP_OKAY, 0);
    add_row(OP_RD, 3'd3, 32'h0000_1040, 0, 4'd1, 0, RESP_OKAY, 64'h0F0F_1E1E_2D2D_3C3C);
    add_row(OP_RD, 3'd3, 32'h0000_1048, 0, 4'd2, 3, RESP_OKAY, ~64'h0F0F_1E1E_2D2D_3C3C);

    repeat (4) @(posedge ACLK);
    @(negedge ACLK);
    check_value("reset bvalid", 0, bvalid_o);
    check_value("reset rvalid", 0, rvalid_o);
    check_value("reset psel", 0, psel_o);
    check_value("reset ready", 3'b111, {awready_o, wready_o, arready_o});
    ARESETn = 1'b1;
    @(negedge ACLK);

    foreach (rows[i])
    begin
      r = rows[i];
      name = $sformatf("row %0d", i);
      case (r.op)
        OP_WR:
        begin
          apply_write(r.id, r.size, r.addr, r.wdata);
          collect_bresp(name, r.id, r.delay, r.resp);
        end
        OP_RD:
        begin
          apply_read(r.id, r.size, r.addr);
          collect_rresp(name, r.id, r.delay, r.resp, r.rdata);
        end
        default:
        begin
          apply_write(r.id, r.size, r.addr, r.wdata);
          apply_write(r.id + 1'b1, r.size, r.addr + 32'd8, ~r.wdata);
          collect_bresp({name, " first"}, r.id, r.delay, r.resp);
          collect_bresp({name, " second"}, r.id + 1'b1, r.delay, r.resp);
        end
      endcase
    end

    if (err_count == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
      report_failure();
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/bridge_pkg.sv
hdl/chan_fifo.sv
hdl/apb_req_if.sv
hdl/apb_master.sv
hdl/beat_sequencer.sv
hdl/axi_apb_bridge.sv
tests/apb_slave_model.sv
tests/tb_axi_apb_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f tb.f --top-module tb_axi_apb_bridge \
    -o sim_tb > build.log 2>&1; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0
